/* project.f */
design/axil_sram_pkg.sv
design/axil_req_decode.sv
design/sram_array.sv
design/axil_resp_stage.sv
design/axil_sram_top.sv
verification/axil_sram_props.sv
verification/axil_sram_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f project.f \
  --top-module axil_sram_tb \
  -o sim_axil_sram
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_axil_sram)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1

/* verification/axil_sram_tb.sv */
// DEPTH 64 with addresses over 128 words; the first 64 writes fill the array, the run ends with a drain
`timescale 1ns/1ps
`default_nettype none

module axil_sram_tb;

  localparam int          DEPTH     = 64;
  localparam int          IW        = $clog2(DEPTH);
  localparam logic [31:0] SEED      = 32'h45fd_4397;
  localparam int          N_CYC     = 3000;
  localparam int          FLOOD_CYC = 40;
  localparam int          STALL_MAX = 64;
  localparam int          DRAIN_MAX = 64;
  localparam logic [1:0]  OKAY      = 2'd0;
  localparam logic [1:0]  SLVERR    = 2'd2;

  logic        i_aclk = 1'b0;
  logic        i_arst_n;
  logic        i_awvalid;
  logic [31:0] i_awaddr;
  logic        i_wvalid;
  logic [63:0] i_wdata;
  logic [7:0]  i_wstrb;
  logic        i_bready;
  logic        i_arvalid;
  logic [31:0] i_araddr;
  logic        i_rready;
  logic        o_awready;
  logic        o_wready;
  logic        o_bvalid;
  logic [1:0]  o_bresp;
  logic        o_arready;
  logic        o_rvalid;
  logic [63:0] o_rdata;
  logic [1:0]  o_rresp;

  logic [31:0] lfsr;
  logic [63:0] model_mem [DEPTH];
  logic [1:0]  bresp_q [$];
  logic [1:0]  rresp_q [$];
  logic [63:0] rdata_q [$];
  logic        fair_wr;
  logic        aw_fire;
  logic        ar_fire;
  logic        b_fire;
  logic        r_fire;
  int          err_cnt;
  int          timeout_cnt;
  int          cross_cnt;
  int          init_cnt;
  int          w_stall;
  int          r_stall;
  int          cyc;
  logic        done;

  axil_sram_top #(
    .DEPTH     (DEPTH)
  ) u_dut (
    .i_aclk    (i_aclk),
    .i_arst_n  (i_arst_n),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_awaddr  (i_awaddr),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .i_araddr  (i_araddr),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp)
  );

  always #10 i_aclk = ~i_aclk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("Error %s: expected %0h actual %0h", name, exp, act);
    err_cnt++;
  endtask

  task automatic check_idle(input string phase);
    logic [4:0] act;
    act = {o_bvalid, o_rvalid, o_awready, o_wready, o_arready};
    assert (act == 5'b0) else report_mismatch(phase, 64'd0, 64'(act));
  endtask

  // Applies the transfers seen before this edge
  task automatic update_model();
    if (b_fire && bresp_q.size() != 0) begin
      void'(bresp_q.pop_front());
    end
    if (r_fire && rresp_q.size() != 0) begin
      void'(rresp_q.pop_front());
      void'(rdata_q.pop_front());
    end
    if (aw_fire) begin
      if (i_awaddr[31:3] < 29'(DEPTH)) begin
        for (int b = 0; b < 8; b++) begin
          if (i_wstrb[b]) begin
            model_mem[i_awaddr[IW+2:3]][b*8 +: 8] = i_wdata[b*8 +: 8];
          end
        end
        bresp_q.push_back(OKAY);
      end else begin
        bresp_q.push_back(SLVERR);
      end
      if (init_cnt < DEPTH) begin
        init_cnt++;
      end
    end
    if (ar_fire) begin
      if (i_araddr[31:3] < 29'(DEPTH)) begin
        rresp_q.push_back(OKAY);
        rdata_q.push_back(model_mem[i_araddr[IW+2:3]]);
      end else begin
        rresp_q.push_back(SLVERR);
        rdata_q.push_back(64'd0);
      end
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    logic [31:0] hi;
    logic [31:0] lo;
    logic        drain;
    logic        flood;
    logic        init_ph;
    logic        aw_hold;
    logic        w_hold;
    drain   = (cyc >= N_CYC);
    flood   = !drain && (cyc >= N_CYC - FLOOD_CYC);
    init_ph = !drain && (init_cnt < DEPTH);
    // A raised valid holds its payload until the write pair is accepted
    aw_hold = i_awvalid && !aw_fire;
    w_hold  = i_wvalid && !aw_fire;
    if (aw_hold || w_hold) begin
      w_stall++;
    end else begin
      w_stall = 0;
    end
    // Either write channel may lead, the other follows while its partner waits
    if (!aw_hold) begin
      take_bits(1, r);
      i_awvalid = w_hold || init_ph || (!drain && (flood || r[0]));
      take_bits(IW + 4, r);
      i_awaddr = init_ph ? (32'(init_cnt) << 3) : 32'(r[IW+3:0]);
    end
    if (!w_hold) begin
      take_bits(1, r);
      i_wvalid = aw_hold || init_ph || (!drain && (flood || r[0]));
      take_bits(32, hi);
      take_bits(32, lo);
      i_wdata = {hi, lo};
      take_bits(8, r);
      i_wstrb = init_ph ? 8'hff : r[7:0];
    end
    if (i_arvalid && !ar_fire) begin
      r_stall++;
    end else begin
      r_stall = 0;
      take_bits(1, r);
      i_arvalid = !init_ph && !drain && (flood || r[0]);
      take_bits(IW + 4, r);
      i_araddr = 32'(r[IW+3:0]);
    end
    take_bits(2, r);
    i_bready = init_ph || flood || drain || (r[1:0] != 2'b00);
    take_bits(2, r);
    i_rready = init_ph || flood || drain || (r[1:0] != 2'b00);
  endtask

  // Runs mid-cycle, where readies and responses have settled
  task automatic check_outputs();
    logic b_free;
    logic r_free;
    logic wr_elig;
    logic rd_elig;
    logic exp_wr;
    logic exp_rd;
    b_free  = (bresp_q.size() == 0) || i_bready;
    r_free  = (rresp_q.size() == 0) || i_rready;
    wr_elig = i_awvalid && i_wvalid && b_free;
    rd_elig = i_arvalid && r_free;
    exp_wr  = wr_elig && (!rd_elig || fair_wr);
    exp_rd  = rd_elig && (!wr_elig || !fair_wr);
    if (wr_elig && rd_elig) begin
      fair_wr = !fair_wr;
    end
    assert (o_awready == exp_wr) else report_mismatch("awready", 64'(exp_wr), 64'(o_awready));
    assert (o_wready == exp_wr) else report_mismatch("wready", 64'(exp_wr), 64'(o_wready));
    assert (o_arready == exp_rd) else report_mismatch("arready", 64'(exp_rd), 64'(o_arready));
    assert (o_bvalid == (bresp_q.size() != 0))
      else report_mismatch("bvalid", 64'(bresp_q.size() != 0), 64'(o_bvalid));
    if (bresp_q.size() != 0) begin
      assert (o_bresp == bresp_q[0]) else report_mismatch("bresp", 64'(bresp_q[0]), 64'(o_bresp));
    end
    assert (o_rvalid == (rresp_q.size() != 0))
      else report_mismatch("rvalid", 64'(rresp_q.size() != 0), 64'(o_rvalid));
    if (rresp_q.size() != 0) begin
      assert (o_rresp == rresp_q[0]) else report_mismatch("rresp", 64'(rresp_q[0]), 64'(o_rresp));
      assert (o_rdata == rdata_q[0]) else report_mismatch("rdata", rdata_q[0], o_rdata);
    end
    aw_fire = i_awvalid && o_awready && i_wvalid && o_wready;
    ar_fire = i_arvalid && o_arready;
    b_fire  = o_bvalid && i_bready;
    r_fire  = o_rvalid && i_rready;
    if ((aw_fire && o_rvalid && !i_rready) || (ar_fire && o_bvalid && !i_bready)) begin
      cross_cnt++;
    end
  endtask

  initial begin
    lfsr        = SEED;
    fair_wr     = 1'b1;
    aw_fire     = 1'b0;
    ar_fire     = 1'b0;
    b_fire      = 1'b0;
    r_fire      = 1'b0;
    err_cnt     = 0;
    timeout_cnt = 0;
    cross_cnt   = 0;
    init_cnt    = 0;
    w_stall     = 0;
    r_stall     = 0;
    cyc         = 0;
    done        = 1'b0;
    i_arst_n    = 1'b0;
    i_awvalid   = 1'b0;
    i_awaddr    = '0;
    i_wvalid    = 1'b0;
    i_wdata     = '0;
    i_wstrb     = '0;
    i_bready    = 1'b0;
    i_arvalid   = 1'b0;
    i_araddr    = '0;
    i_rready    = 1'b0;

    @(posedge i_aclk);
    #5;
    check_idle("reset state");
    @(posedge i_aclk);
    #2;
    i_arst_n = 1'b1;
    @(negedge i_aclk);
    check_idle("first cycle after reset");

    while (!done) begin
      @(posedge i_aclk);
      update_model();
      #2;
      drive_inputs();
      if (w_stall > STALL_MAX || r_stall > STALL_MAX) begin
        $display("A request waited more than %0d cycles for its ready", STALL_MAX);
        timeout_cnt++;
        break;
      end
      @(negedge i_aclk);
      check_outputs();
      cyc++;
      if (cyc >= N_CYC && !i_awvalid && !i_wvalid && !i_arvalid &&
          bresp_q.size() == 0 && rresp_q.size() == 0) begin
        done = 1'b1;
      end else if (cyc > N_CYC + DRAIN_MAX) begin
        $display("Outstanding requests did not drain within %0d cycles", DRAIN_MAX);
        timeout_cnt++;
        break;
      end
    end

    assert (cross_cnt > 0) else begin
      $display("No access was accepted on one channel while the other channel was stalled");
      err_cnt++;
    end

    $display("Checks failed: %0d, timeouts: %0d", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/axil_sram_props.sv */
// Bound into axil_sram_top; payload checks apply only while a response waits for its ready
`timescale 1ns/1ps
`default_nettype none

module axil_sram_props (
  input wire logic                             i_aclk,
  input wire logic                             i_arst_n,
  input wire logic                             i_awready,
  input wire logic                             i_wready,
  input wire logic                             i_arready,
  input wire logic                             i_bvalid,
  input wire logic                             i_bready,
  input wire logic [1:0]                       i_bresp,
  input wire logic                             i_rvalid,
  input wire logic                             i_rready,
  input wire logic [axil_sram_pkg::DATA_W-1:0] i_rdata,
  input wire logic [1:0]                       i_rresp
);

  b_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    (i_bvalid && !i_bready) |=> (i_bvalid && $stable(i_bresp)))
    else $error("B response changed while BREADY was low");

  r_hold: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    (i_rvalid && !i_rready) |=> (i_rvalid && $stable(i_rresp) && $stable(i_rdata)))
    else $error("R response changed while RREADY was low");

  reset_idle: assert property (@(posedge i_aclk)
    !i_arst_n |-> !(i_awready || i_wready || i_arready || i_bvalid || i_rvalid))
    else $error("A ready or valid is high during reset");

endmodule

bind axil_sram_top axil_sram_props u_props (
  .i_aclk    (i_aclk),
  .i_arst_n  (i_arst_n),
  .i_awready (o_awready),
  .i_wready  (o_wready),
  .i_arready (o_arready),
  .i_bvalid  (o_bvalid),
  .i_bready  (i_bready),
  .i_bresp   (o_bresp),
  .i_rvalid  (o_rvalid),
  .i_rready  (i_rready),
  .i_rdata   (o_rdata),
  .i_rresp   (o_rresp)
);

`default_nettype wire

/* design/axil_sram_top.sv */
// AXI-lite slave SRAM; DEPTH words of 64 bits, DEPTH at most 2^29, no PROT, low address bits ignored
`timescale 1ns/1ps
`default_nettype none

module axil_sram_top #(
  parameter int DEPTH = 1024
) (
  input  wire logic                            i_aclk,
  input  wire logic                            i_arst_n,

  // Write address
  input  wire logic                            i_awvalid,
  output logic                                 o_awready,
  input  wire logic [axil_sram_pkg::ADDR_W-1:0] i_awaddr,

  // Write data
  input  wire logic                            i_wvalid,
  output logic                                 o_wready,
  input  wire logic [axil_sram_pkg::DATA_W-1:0] i_wdata,
  input  wire logic [axil_sram_pkg::STRB_W-1:0] i_wstrb,

  // Write response
  output logic                                 o_bvalid,
  input  wire logic                            i_bready,
  output logic [1:0]                           o_bresp,

  // Read address
  input  wire logic                            i_arvalid,
  output logic                                 o_arready,
  input  wire logic [axil_sram_pkg::ADDR_W-1:0] i_araddr,

  // Read data
  output logic                                 o_rvalid,
  input  wire logic                            i_rready,
  output logic [axil_sram_pkg::DATA_W-1:0]     o_rdata,
  output logic [1:0]                           o_rresp
);

  import axil_sram_pkg::*;

  mem_req_t          mem_req;
  cpl_t              cpl;
  logic [DATA_W-1:0] mem_rdata;
  logic              b_free;
  logic              r_free;

  axil_req_decode #(
    .DEPTH       (DEPTH)
  ) u_decode (
    .i_aclk      (i_aclk),
    .i_arst_n    (i_arst_n),
    .i_awvalid   (i_awvalid),
    .i_awaddr    (i_awaddr),
    .i_wvalid    (i_wvalid),
    .i_wdata     (i_wdata),
    .i_wstrb     (i_wstrb),
    .i_arvalid   (i_arvalid),
    .i_araddr    (i_araddr),
    .i_b_free    (b_free),
    .i_r_free    (r_free),
    .o_awready   (o_awready),
    .o_wready    (o_wready),
    .o_arready   (o_arready),
    .o_req       (mem_req),
    .o_cpl       (cpl)
  );

  sram_array #(
    .DEPTH       (DEPTH)
  ) u_sram (
    .i_aclk      (i_aclk),
    .i_req       (mem_req),
    .o_rdata     (mem_rdata)
  );

  axil_resp_stage u_resp (
    .i_aclk      (i_aclk),
    .i_arst_n    (i_arst_n),
    .i_cpl       (cpl),
    .i_mem_rdata (mem_rdata),
    .i_bready    (i_bready),
    .i_rready    (i_rready),
    .o_bvalid    (o_bvalid),
    .o_bresp     (o_bresp),
    .o_rvalid    (o_rvalid),
    .o_rresp     (o_rresp),
    .o_rdata     (o_rdata),
    .o_b_free    (b_free),
    .o_r_free    (r_free)
  );

endmodule

`default_nettype wire

/* design/axil_resp_stage.sv */
// Holds one B and one R response; a new completion arrives only when its slot is free
`timescale 1ns/1ps
`default_nettype none

module axil_resp_stage (
  input  wire logic                            i_aclk,
  input  wire logic                            i_arst_n,

  input  axil_sram_pkg::cpl_t                  i_cpl,
  input  wire logic [axil_sram_pkg::DATA_W-1:0] i_mem_rdata,
  input  wire logic                            i_bready,
  input  wire logic                            i_rready,

  output logic                                 o_bvalid,
  output axil_sram_pkg::resp_e                 o_bresp,
  output logic                                 o_rvalid,
  output axil_sram_pkg::resp_e                 o_rresp,
  output logic [axil_sram_pkg::DATA_W-1:0]     o_rdata,

  output logic                                 o_b_free,
  output logic                                 o_r_free
);

  import axil_sram_pkg::*;

  logic  bvalid_q;
  logic  rvalid_q;
  resp_e bresp_q;
  logic  rerr_q;

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (i_cpl.wr_done) begin
        bvalid_q <= 1'b1;
      end else if (i_bready) begin
        bvalid_q <= 1'b0;
      end

      if (i_cpl.rd_done) begin
        rvalid_q <= 1'b1;
      end else if (i_rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Response payload, loaded only at acceptance
  always_ff @(posedge i_aclk) begin
    if (i_cpl.wr_done) begin
      bresp_q <= i_cpl.err ? RESP_SLVERR : RESP_OKAY;
    end
    if (i_cpl.rd_done) begin
      rerr_q <= i_cpl.err;
    end
  end

  assign o_bvalid = bvalid_q;
  assign o_bresp  = bresp_q;
  assign o_rvalid = rvalid_q;
  assign o_rresp  = rerr_q ? RESP_SLVERR : RESP_OKAY;

  // A failed read left the SRAM register untouched, so mask it
  assign o_rdata  = rerr_q ? '0 : i_mem_rdata;

  assign o_b_free = ~bvalid_q | i_bready;
  assign o_r_free = ~rvalid_q | i_rready;

endmodule

`default_nettype wire

/* design/sram_array.sv */
// Index must be in range on any enable; read register has no reset, holds until the next read
`timescale 1ns/1ps
`default_nettype none

module sram_array #(
  parameter int DEPTH = 1024
) (
  input  wire logic                            i_aclk,
  input  axil_sram_pkg::mem_req_t              i_req,
  output logic [axil_sram_pkg::DATA_W-1:0]     o_rdata
);

  import axil_sram_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [DATA_W-1:0] mem [DEPTH];
  logic [DATA_W-1:0] rdata_q;
  logic [AW-1:0]     word_addr;

  // Upper index bits are zero for any enabled access
  assign word_addr = i_req.idx[AW-1:0];

  always_ff @(posedge i_aclk) begin
    if (i_req.wr_en) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (i_req.wstrb[b]) begin
          mem[word_addr][b*8 +: 8] <= i_req.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Stable under R back-pressure
  always_ff @(posedge i_aclk) begin
    if (i_req.rd_en) begin
      rdata_q <= mem[word_addr];
    end
  end

  assign o_rdata = rdata_q;

endmodule

`default_nettype wire

/* design/axil_req_decode.sv */
// Readies are combinational on valids and slot-free levels; masters must hold valid and payload
`timescale 1ns/1ps
`default_nettype none

module axil_req_decode #(
  parameter int DEPTH = 1024
) (
  input  wire logic                            i_aclk,
  input  wire logic                            i_arst_n,

  input  wire logic                            i_awvalid,
  input  wire logic [axil_sram_pkg::ADDR_W-1:0] i_awaddr,
  input  wire logic                            i_wvalid,
  input  wire logic [axil_sram_pkg::DATA_W-1:0] i_wdata,
  input  wire logic [axil_sram_pkg::STRB_W-1:0] i_wstrb,
  input  wire logic                            i_arvalid,
  input  wire logic [axil_sram_pkg::ADDR_W-1:0] i_araddr,

  input  wire logic                            i_b_free,
  input  wire logic                            i_r_free,

  output logic                                 o_awready,
  output logic                                 o_wready,
  output logic                                 o_arready,

  output axil_sram_pkg::mem_req_t              o_req,
  output axil_sram_pkg::cpl_t                  o_cpl
);

  import axil_sram_pkg::*;

  // One extra bit so a DEPTH of 2^IDX_W still fits
  localparam logic [IDX_W:0] LIMIT = (IDX_W+1)'(DEPTH);

  logic             wr_elig;
  logic             rd_elig;
  logic             wr_go;
  logic             rd_go;
  logic             wr_ok;
  logic             rd_ok;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;

  // High when writes win the next conflict
  logic             wr_pri_q;

  assign wr_elig = i_awvalid & i_wvalid & i_b_free;
  assign rd_elig = i_arvalid & i_r_free;

  assign wr_go = wr_elig & (~rd_elig | wr_pri_q);
  assign rd_go = rd_elig & (~wr_elig | ~wr_pri_q);

  assign o_awready = wr_go;
  assign o_wready  = wr_go;
  assign o_arready = rd_go;

  // Byte offset bits are ignored
  assign wr_idx = i_awaddr[ADDR_W-1:3];
  assign rd_idx = i_araddr[ADDR_W-1:3];

  assign wr_ok = ({1'b0, wr_idx} < LIMIT);
  assign rd_ok = ({1'b0, rd_idx} < LIMIT);

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_pri_q <= 1'b1;
    end else if (wr_elig && rd_elig) begin
      wr_pri_q <= ~wr_pri_q;
    end
  end

  // Out-of-range accesses never reach the array
  always_comb begin
    o_req.wr_en = wr_go & wr_ok;
    o_req.rd_en = rd_go & rd_ok;
    o_req.idx   = wr_go ? wr_idx : rd_idx;
    o_req.wdata = i_wdata;
    o_req.wstrb = i_wstrb;
  end

  always_comb begin
    o_cpl.wr_done = wr_go;
    o_cpl.rd_done = rd_go;
    if (wr_go) begin
      o_cpl.err = ~wr_ok;
    end else begin
      o_cpl.err = rd_go & ~rd_ok;
    end
  end

endmodule

`default_nettype wire

/* design/axil_sram_pkg.sv */
// Fixed 64-bit data and 32-bit address AXI-lite widths; only OKAY and SLVERR responses exist
`default_nettype none

package axil_sram_pkg;

  localparam int DATA_W = 64;
  localparam int ADDR_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Word index after dropping the three byte-offset bits
  localparam int IDX_W = ADDR_W - 3;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } resp_e;

  // One SRAM access, at most one per cycle
  typedef struct packed {
    logic              wr_en;
    logic              rd_en;
    logic [IDX_W-1:0]  idx;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } mem_req_t;

  // Completion seen by the response stage in the acceptance cycle
  typedef struct packed {
    logic wr_done;
    logic rd_done;
    logic err;
  } cpl_t;

endpackage

`default_nettype wire
